//--- hw/csr_pkg.sv
package csr_pkg;

  // machine csr addresses.
  localparam logic [11:0] CSR_MSTATUS = 12'h300;
  localparam logic [11:0] CSR_MTVEC   = 12'h305;
  localparam logic [11:0] CSR_MEPC    = 12'h341;
  localparam logic [11:0] CSR_MCAUSE  = 12'h342;

  // mstatus bit positions.
  localparam int MSTATUS_MIE  = 3;
  localparam int MSTATUS_MPIE = 7;

  // environment call from m-mode.
  localparam logic [31:0] CAUSE_ECALL_M = 32'd11;

  // the immediate forms share these ops, the decoder puts zimm in src1.
  typedef enum logic [1:0] {
    CSR_RW,
    CSR_RS,
    CSR_RC
  } csr_op_e;

endpackage

//--- hw/exu_pkg.sv
package exu_pkg;
  import csr_pkg::*;

  localparam int XLEN = 32;

  typedef enum logic [2:0] {
    OP_ALU,
    OP_BRANCH,
    OP_JUMP,
    OP_LOAD,
    OP_STORE,
    OP_SYSTEM
  } op_class_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_EQ,
    BR_NE,
    BR_LT,
    BR_GE,
    BR_LTU,
    BR_GEU
  } br_cond_e;

  typedef enum logic [2:0] {
    SYS_NONE,
    SYS_CSR,
    SYS_ECALL,
    SYS_EBREAK,
    SYS_MRET
  } sys_op_e;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_EXEC,
    ST_MEM,
    ST_HOLD
  } ctrl_state_e;

  // for i-type alu ops the decoder puts the immediate in src2.
  // jalr selects src1 as the jump base, pc otherwise.
  typedef struct packed {
    logic [XLEN-1:0] pc;
    op_class_e       op_class;
    alu_op_e         alu_op;
    br_cond_e        br_cond;
    sys_op_e         sys_op;
    csr_op_e         csr_op;
    logic [11:0]     csr_addr;
    logic [XLEN-1:0] src1;
    logic [XLEN-1:0] src2;
    logic [XLEN-1:0] imm;
    logic            jalr;
    logic [4:0]      rd;
    logic            rd_wen;
  } exu_issue_t;

  typedef struct packed {
    logic [4:0]      rd;
    logic            rd_wen;
    logic [XLEN-1:0] wdata;
    logic [XLEN-1:0] npc;
    logic            ebreak;
  } exu_wb_t;

endpackage

//--- hw/exu_ctrl.sv
`timescale 1ns/1ps

module exu_ctrl import exu_pkg::*; (
  input  logic clk,
  input  logic rst,
  input  logic in_valid_i,
  input  logic issue_mem_i,
  input  logic issue_store_i,
  input  logic wb_ready_i,
  input  logic lsu_done_i,
  output logic in_ready_o,
  output logic accept_o,
  output logic lsu_req_o,
  output logic commit_o,
  output logic wb_valid_o
);

  ctrl_state_e state_q;
  logic        go_mem;

  // issue_mem_i flags a load, issue_store_i a store.
  assign go_mem     = issue_mem_i | issue_store_i;
  assign in_ready_o = (state_q == ST_IDLE);
  assign accept_o   = in_valid_i & in_ready_o;
  assign lsu_req_o  = accept_o & go_mem;
  assign commit_o   = (state_q == ST_EXEC) | ((state_q == ST_MEM) & lsu_done_i);
  assign wb_valid_o = (state_q == ST_HOLD);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (accept_o) begin
            state_q <= go_mem ? ST_MEM : ST_EXEC;
          end
        end
        ST_EXEC: begin
          state_q <= ST_HOLD;
        end
        ST_MEM: begin
          if (lsu_done_i) begin
            state_q <= ST_HOLD;
          end
        end
        ST_HOLD: begin
          if (wb_ready_i) begin
            state_q <= ST_IDLE;
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // result is held until the sink takes it.
  a_wb_hold: assert property (@(posedge clk) disable iff (rst)
    wb_valid_o && !wb_ready_i |=> wb_valid_o);

  // the lsu only finishes a request this fsm issued.
  a_done_in_mem: assert property (@(posedge clk) disable iff (rst)
    lsu_done_i |-> state_q == ST_MEM);

endmodule

//--- hw/exu_alu.sv
`timescale 1ns/1ps

module exu_alu import exu_pkg::*; (
  input  logic [XLEN-1:0] a_i,
  input  logic [XLEN-1:0] b_i,
  input  alu_op_e         op_i,
  output logic [XLEN-1:0] res_o
);

  logic [4:0] shamt;

  assign shamt = b_i[4:0];

  always_comb begin
    case (op_i)
      ALU_ADD:  res_o = a_i + b_i;
      ALU_SUB:  res_o = a_i - b_i;
      ALU_AND:  res_o = a_i & b_i;
      ALU_OR:   res_o = a_i | b_i;
      ALU_XOR:  res_o = a_i ^ b_i;
      ALU_SLL:  res_o = a_i << shamt;
      ALU_SRL:  res_o = a_i >> shamt;
      ALU_SRA:  res_o = $unsigned($signed(a_i) >>> shamt);
      ALU_SLT:  res_o = {{(XLEN-1){1'b0}}, $signed(a_i) < $signed(b_i)};
      ALU_SLTU: res_o = {{(XLEN-1){1'b0}}, a_i < b_i};
      default:  res_o = '0;
    endcase
  end

endmodule

//--- hw/exu_branch.sv
`timescale 1ns/1ps

module exu_branch import exu_pkg::*; (
  input  exu_issue_t      issue_i,
  input  logic [XLEN-1:0] mtvec_i,
  input  logic [XLEN-1:0] mepc_i,
  output logic [XLEN-1:0] npc_o
);

  logic            taken;
  logic [XLEN-1:0] jump_base;
  logic [XLEN-1:0] jump_tgt;

  always_comb begin
    case (issue_i.br_cond)
      BR_EQ:   taken = (issue_i.src1 == issue_i.src2);
      BR_NE:   taken = (issue_i.src1 != issue_i.src2);
      BR_LT:   taken = ($signed(issue_i.src1) < $signed(issue_i.src2));
      BR_GE:   taken = ($signed(issue_i.src1) >= $signed(issue_i.src2));
      BR_LTU:  taken = (issue_i.src1 < issue_i.src2);
      BR_GEU:  taken = (issue_i.src1 >= issue_i.src2);
      default: taken = 1'b0;
    endcase
  end

  // jal is pc relative, jalr is register relative.
  assign jump_base = issue_i.jalr ? issue_i.src1 : issue_i.pc;
  assign jump_tgt  = (jump_base + issue_i.imm) & ~{{(XLEN-1){1'b0}}, 1'b1};

  always_comb begin
    npc_o = issue_i.pc + 32'd4;
    case (issue_i.op_class)
      OP_BRANCH: begin
        if (taken) begin
          npc_o = issue_i.pc + issue_i.imm;
        end
      end
      OP_JUMP: begin
        npc_o = jump_tgt;
      end
      OP_SYSTEM: begin
        if (issue_i.sys_op == SYS_ECALL) begin
          npc_o = mtvec_i;
        end else if (issue_i.sys_op == SYS_MRET) begin
          npc_o = mepc_i;
        end
      end
      default: begin
      end
    endcase
  end

endmodule

//--- hw/exu_csr_file.sv
`timescale 1ns/1ps

module exu_csr_file import exu_pkg::*; import csr_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic            commit_i,
  input  exu_issue_t      issue_i,
  output logic [XLEN-1:0] rdata_o,
  output logic [XLEN-1:0] mtvec_o,
  output logic [XLEN-1:0] mepc_o
);

  logic [XLEN-1:0] mstatus_q;
  logic [XLEN-1:0] mtvec_q;
  logic [XLEN-1:0] mepc_q;
  logic [XLEN-1:0] mcause_q;
  logic [XLEN-1:0] wval;
  logic            is_sys;

  assign is_sys  = (issue_i.op_class == OP_SYSTEM);
  assign mtvec_o = mtvec_q;
  assign mepc_o  = mepc_q;

  always_comb begin
    case (issue_i.csr_addr)
      CSR_MSTATUS: rdata_o = mstatus_q;
      CSR_MTVEC:   rdata_o = mtvec_q;
      CSR_MEPC:    rdata_o = mepc_q;
      CSR_MCAUSE:  rdata_o = mcause_q;
      default:     rdata_o = '0;
    endcase
  end

  always_comb begin
    case (issue_i.csr_op)
      CSR_RS:  wval = rdata_o | issue_i.src1;
      CSR_RC:  wval = rdata_o & ~issue_i.src1;
      default: wval = issue_i.src1;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus_q <= '0;
      mtvec_q   <= '0;
      mepc_q    <= '0;
      mcause_q  <= '0;
    end else if (commit_i && is_sys) begin
      case (issue_i.sys_op)
        SYS_CSR: begin
          case (issue_i.csr_addr)
            CSR_MSTATUS: mstatus_q <= wval;
            CSR_MTVEC:   mtvec_q   <= wval;
            CSR_MEPC:    mepc_q    <= wval;
            CSR_MCAUSE:  mcause_q  <= wval;
            default: begin
            end
          endcase
        end
        SYS_ECALL: begin
          mepc_q   <= issue_i.pc;
          mcause_q <= CAUSE_ECALL_M;
        end
        SYS_MRET: begin
          mstatus_q[MSTATUS_MIE]  <= mstatus_q[MSTATUS_MPIE];
          mstatus_q[MSTATUS_MPIE] <= 1'b1;
        end
        default: begin
        end
      endcase
    end
  end

  // one commit per instruction, even under back-pressure.
  a_single_commit: assert property (@(posedge clk) disable iff (rst)
    commit_i |=> !commit_i);

endmodule

//--- hw/exu_lsu_apb.sv
`timescale 1ns/1ps

module exu_lsu_apb import exu_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic            req_i,
  input  logic            write_i,
  input  logic [XLEN-1:0] addr_i,
  input  logic [XLEN-1:0] wdata_i,
  output logic            done_o,
  output logic [XLEN-1:0] rdata_o,
  output logic [XLEN-1:0] paddr_o,
  output logic            psel_o,
  output logic            penable_o,
  output logic            pwrite_o,
  output logic [XLEN-1:0] pwdata_o,
  input  logic [XLEN-1:0] prdata_i,
  input  logic            pready_i,
  input  logic            pslverr_i
);

  logic            psel_q;
  logic            penable_q;
  logic            done_q;
  logic [XLEN-1:0] rdata_q;
  logic            xfer_end;

  // address and data come from the latched issue record, stable for the whole transfer.
  assign paddr_o   = addr_i;
  assign pwdata_o  = wdata_i;
  assign pwrite_o  = write_i;
  assign psel_o    = psel_q;
  assign penable_o = penable_q;
  assign done_o    = done_q;
  assign rdata_o   = rdata_q;
  assign xfer_end  = psel_q & penable_q & pready_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      psel_q    <= 1'b0;
      penable_q <= 1'b0;
      done_q    <= 1'b0;
    end else begin
      done_q <= xfer_end;
      if (req_i) begin
        psel_q    <= 1'b1;
        penable_q <= 1'b0;
      end else if (psel_q && !penable_q) begin
        penable_q <= 1'b1;
      end else if (xfer_end) begin
        psel_q    <= 1'b0;
        penable_q <= 1'b0;
      end
    end
  end

  // a slave error reads as zero.
  always_ff @(posedge clk) begin
    if (xfer_end) begin
      rdata_q <= pslverr_i ? '0 : prdata_i;
    end
  end

  a_apb_stable: assert property (@(posedge clk) disable iff (rst)
    psel_o && penable_o |-> $stable(paddr_o) && $stable(pwdata_o));

endmodule

//--- hw/exu_top.sv
`timescale 1ns/1ps

module exu_top import exu_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic            in_valid_i,
  input  exu_issue_t      in_issue_i,
  output logic            in_ready_o,
  output logic            wb_valid_o,
  output exu_wb_t         wb_o,
  input  logic            wb_ready_i,
  output logic [XLEN-1:0] paddr_o,
  output logic            psel_o,
  output logic            penable_o,
  output logic            pwrite_o,
  output logic [XLEN-1:0] pwdata_o,
  input  logic [XLEN-1:0] prdata_i,
  input  logic            pready_i,
  input  logic            pslverr_i
);

  exu_issue_t      issue_q;
  exu_wb_t         wb_q;
  exu_wb_t         wb_d;
  logic            accept;
  logic            lsu_req;
  logic            lsu_done;
  logic            commit;
  logic            is_mem;
  alu_op_e         alu_op;
  logic [XLEN-1:0] alu_b;
  logic [XLEN-1:0] alu_res;
  logic [XLEN-1:0] lsu_rdata;
  logic [XLEN-1:0] csr_rdata;
  logic [XLEN-1:0] mtvec;
  logic [XLEN-1:0] mepc;
  logic [XLEN-1:0] npc;

  exu_ctrl u_ctrl (
    .clk          (clk),
    .rst          (rst),
    .in_valid_i   (in_valid_i),
    .issue_mem_i  (in_issue_i.op_class == OP_LOAD),
    .issue_store_i(in_issue_i.op_class == OP_STORE),
    .wb_ready_i   (wb_ready_i),
    .lsu_done_i   (lsu_done),
    .in_ready_o   (in_ready_o),
    .accept_o     (accept),
    .lsu_req_o    (lsu_req),
    .commit_o     (commit),
    .wb_valid_o   (wb_valid_o)
  );

  always_ff @(posedge clk) begin
    if (accept) begin
      issue_q <= in_issue_i;
    end
  end

  // loads and stores use the alu for src1 + imm.
  assign is_mem = (issue_q.op_class == OP_LOAD) || (issue_q.op_class == OP_STORE);
  assign alu_op = is_mem ? ALU_ADD : issue_q.alu_op;
  assign alu_b  = is_mem ? issue_q.imm : issue_q.src2;

  exu_alu u_alu (
    .a_i  (issue_q.src1),
    .b_i  (alu_b),
    .op_i (alu_op),
    .res_o(alu_res)
  );

  exu_branch u_branch (
    .issue_i(issue_q),
    .mtvec_i(mtvec),
    .mepc_i (mepc),
    .npc_o  (npc)
  );

  exu_csr_file u_csr (
    .clk     (clk),
    .rst     (rst),
    .commit_i(commit),
    .issue_i (issue_q),
    .rdata_o (csr_rdata),
    .mtvec_o (mtvec),
    .mepc_o  (mepc)
  );

  exu_lsu_apb u_lsu (
    .clk      (clk),
    .rst      (rst),
    .req_i    (lsu_req),
    .write_i  (issue_q.op_class == OP_STORE),
    .addr_i   (alu_res),
    .wdata_i  (issue_q.src2),
    .done_o   (lsu_done),
    .rdata_o  (lsu_rdata),
    .paddr_o  (paddr_o),
    .psel_o   (psel_o),
    .penable_o(penable_o),
    .pwrite_o (pwrite_o),
    .pwdata_o (pwdata_o),
    .prdata_i (prdata_i),
    .pready_i (pready_i),
    .pslverr_i(pslverr_i)
  );

  always_comb begin
    wb_d.rd     = issue_q.rd;
    wb_d.rd_wen = issue_q.rd_wen;
    wb_d.npc    = npc;
    wb_d.ebreak = (issue_q.op_class == OP_SYSTEM) && (issue_q.sys_op == SYS_EBREAK);
    if (issue_q.op_class == OP_LOAD) begin
      wb_d.wdata = lsu_rdata;
    end else if (issue_q.op_class == OP_SYSTEM && issue_q.sys_op == SYS_CSR) begin
      wb_d.wdata = csr_rdata;
    end else if (issue_q.op_class == OP_JUMP) begin
      wb_d.wdata = issue_q.pc + 32'd4;
    end else begin
      wb_d.wdata = alu_res;
    end
  end

  // captured on the commit edge, held through back-pressure.
  always_ff @(posedge clk) begin
    if (commit) begin
      wb_q <= wb_d;
    end
  end

  assign wb_o = wb_q;

endmodule

//--- tb/exu_apb_mem.sv
`timescale 1ns/1ps

module exu_apb_mem import exu_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic [1:0]      wait_i,
  input  logic [XLEN-1:0] paddr_i,
  input  logic            psel_i,
  input  logic            penable_i,
  input  logic            pwrite_i,
  input  logic [XLEN-1:0] pwdata_i,
  output logic [XLEN-1:0] prdata_o,
  output logic            pready_o,
  output logic            pslverr_o
);

  logic [XLEN-1:0] mem [256];
  logic [1:0]      wait_q;
  logic [1:0]      cnt_q;

  // each word starts out holding its own index.
  initial begin
    for (int i = 0; i < 256; i++) begin
      mem[i] = 32'hc0de_0000 | i;
    end
  end

  assign pready_o  = psel_i & penable_i & (cnt_q == wait_q);
  assign prdata_o  = mem[paddr_i[9:2]];
  assign pslverr_o = 1'b0;

  always_ff @(posedge clk) begin
    if (rst) begin
      wait_q <= '0;
      cnt_q  <= '0;
    end else if (psel_i && !penable_i) begin
      // wait count is picked in the setup phase.
      wait_q <= wait_i;
      cnt_q  <= '0;
    end else if (psel_i && penable_i && !pready_o) begin
      cnt_q <= cnt_q + 2'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (pready_o && pwrite_i) begin
      mem[paddr_i[9:2]] <= pwdata_i;
    end
  end

endmodule

//--- tb/exu_tb.sv
`timescale 1ns/1ps

module exu_tb import exu_pkg::*; import csr_pkg::*; ();

  logic            clk;
  logic            rst;
  logic            in_valid_i;
  exu_issue_t      in_issue_i;
  logic            in_ready_o;
  logic            wb_valid_o;
  exu_wb_t         wb_o;
  logic            wb_ready_i;
  logic [XLEN-1:0] paddr;
  logic            psel;
  logic            penable;
  logic            pwrite;
  logic [XLEN-1:0] pwdata;
  logic [XLEN-1:0] prdata;
  logic            pready;
  logic            pslverr;
  logic [1:0]      wait_sel;

  exu_wb_t         exp_wb;
  logic [31:0]     exp_addr;
  logic            exp_write;
  logic            bp_en;
  logic [31:0]     rng;
  logic [31:0]     r_ready;
  logic [31:0]     r_wait;
  int              errors;
  int              timeouts;

  // reference state.
  logic [31:0] m_mstatus;
  logic [31:0] m_mtvec;
  logic [31:0] m_mepc;
  logic [31:0] m_mcause;
  logic [31:0] mem_img [logic [31:0]];

  exu_top DUT (
    .clk       (clk),
    .rst       (rst),
    .in_valid_i(in_valid_i),
    .in_issue_i(in_issue_i),
    .in_ready_o(in_ready_o),
    .wb_valid_o(wb_valid_o),
    .wb_o      (wb_o),
    .wb_ready_i(wb_ready_i),
    .paddr_o   (paddr),
    .psel_o    (psel),
    .penable_o (penable),
    .pwrite_o  (pwrite),
    .pwdata_o  (pwdata),
    .prdata_i  (prdata),
    .pready_i  (pready),
    .pslverr_i (pslverr)
  );

  exu_apb_mem u_mem (
    .clk      (clk),
    .rst      (rst),
    .wait_i   (wait_sel),
    .paddr_i  (paddr),
    .psel_i   (psel),
    .penable_i(penable),
    .pwrite_i (pwrite),
    .pwdata_i (pwdata),
    .prdata_o (prdata),
    .pready_o (pready),
    .pslverr_o(pslverr)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng = x;
    return x;
  endfunction

  always @(negedge clk) begin
    r_ready = next_rand();
    r_wait  = next_rand();
  end

  always @(posedge clk) begin
    wb_ready_i <= bp_en ? r_ready[0] : 1'b1;
    wait_sel   <= r_wait[1:0];
  end

  always @(posedge clk) begin
    if (psel && penable && pready && pslverr) begin
      $display("warning: slave error on access to %h", paddr);
    end
  end

  // checks.
  a_wb_value: assert property (@(posedge clk) disable iff (rst)
    wb_valid_o && wb_ready_i |-> wb_o == exp_wb)
    else begin
      errors++;
      $display("Mismatch wb_o: got %h expected %h", $sampled(wb_o), $sampled(exp_wb));
    end

  a_latency: assert property (@(posedge clk) disable iff (rst)
    in_valid_i && in_ready_o && !(in_issue_i.op_class inside {OP_LOAD, OP_STORE})
    |=> !wb_valid_o ##1 wb_valid_o)
    else begin
      errors++;
      $display("result of a non-memory instruction did not appear one cycle after accept");
    end

  a_backpressure: assert property (@(posedge clk) disable iff (rst)
    wb_valid_o && !wb_ready_i |=> wb_valid_o && $stable(wb_o) && !in_ready_o)
    else begin
      errors++;
      $display("result or ready changed while the sink stalled");
    end

  a_release: assert property (@(posedge clk) disable iff (rst)
    wb_valid_o && wb_ready_i |=> in_ready_o && !wb_valid_o)
    else begin
      errors++;
      $display("in_ready_o did not return high after the writeback transfer");
    end

  a_apb_access: assert property (@(posedge clk) disable iff (rst)
    psel && !penable |=> psel && penable && $stable(paddr) && $stable(pwdata))
    else begin
      errors++;
      $display("apb access phase did not follow the setup phase");
    end

  a_paddr: assert property (@(posedge clk) disable iff (rst)
    psel |-> paddr == exp_addr)
    else begin
      errors++;
      $display("Mismatch paddr: got %h expected %h", $sampled(paddr), $sampled(exp_addr));
    end

  a_pwrite: assert property (@(posedge clk) disable iff (rst)
    psel |-> pwrite == exp_write)
    else begin
      errors++;
      $display("Mismatch pwrite: got %h expected %h", $sampled(pwrite), $sampled(exp_write));
    end

  function automatic logic [31:0] alu_ref(alu_op_e op, logic [31:0] a, logic [31:0] b);
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_AND:  return a & b;
      ALU_OR:   return a | b;
      ALU_XOR:  return a ^ b;
      ALU_SLL:  return a << b[4:0];
      ALU_SRL:  return a >> b[4:0];
      ALU_SRA:  return $unsigned($signed(a) >>> b[4:0]);
      ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
      default:  return 32'd0;
    endcase
  endfunction

  function automatic logic branch_taken(br_cond_e c, logic [31:0] a, logic [31:0] b);
    case (c)
      BR_EQ:   return a == b;
      BR_NE:   return a != b;
      BR_LT:   return $signed(a) < $signed(b);
      BR_GE:   return $signed(a) >= $signed(b);
      BR_LTU:  return a < b;
      BR_GEU:  return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [31:0] csr_read(logic [11:0] addr);
    case (addr)
      CSR_MSTATUS: return m_mstatus;
      CSR_MTVEC:   return m_mtvec;
      CSR_MEPC:    return m_mepc;
      CSR_MCAUSE:  return m_mcause;
      default:     return 32'd0;
    endcase
  endfunction

  function automatic exu_wb_t predict(exu_issue_t i);
    exu_wb_t w;
    w.rd     = i.rd;
    w.rd_wen = i.rd_wen;
    w.npc    = i.pc + 32'd4;
    w.ebreak = 1'b0;
    w.wdata  = alu_ref(i.alu_op, i.src1, i.src2);
    case (i.op_class)
      OP_BRANCH: begin
        if (branch_taken(i.br_cond, i.src1, i.src2)) begin
          w.npc = i.pc + i.imm;
        end
      end
      OP_JUMP: begin
        w.npc   = ((i.jalr ? i.src1 : i.pc) + i.imm) & ~32'd1;
        w.wdata = i.pc + 32'd4;
      end
      OP_LOAD:  w.wdata = mem_img[i.src1 + i.imm];
      OP_STORE: w.wdata = i.src1 + i.imm;
      OP_SYSTEM: begin
        case (i.sys_op)
          SYS_CSR:    w.wdata = csr_read(i.csr_addr);
          SYS_ECALL:  w.npc = m_mtvec;
          SYS_MRET:   w.npc = m_mepc;
          SYS_EBREAK: w.ebreak = 1'b1;
          default: begin
          end
        endcase
      end
      default: begin
      end
    endcase
    return w;
  endfunction

  task automatic apply_model(exu_issue_t i);
    logic [31:0] old;
    logic [31:0] nv;
    if (i.op_class == OP_STORE) begin
      mem_img[i.src1 + i.imm] = i.src2;
    end else if (i.op_class == OP_SYSTEM && i.sys_op == SYS_CSR) begin
      old = csr_read(i.csr_addr);
      case (i.csr_op)
        CSR_RS:  nv = old | i.src1;
        CSR_RC:  nv = old & ~i.src1;
        default: nv = i.src1;
      endcase
      case (i.csr_addr)
        CSR_MSTATUS: m_mstatus = nv;
        CSR_MTVEC:   m_mtvec = nv;
        CSR_MEPC:    m_mepc = nv;
        CSR_MCAUSE:  m_mcause = nv;
        default: begin
        end
      endcase
    end else if (i.op_class == OP_SYSTEM && i.sys_op == SYS_ECALL) begin
      m_mepc   = i.pc;
      m_mcause = CAUSE_ECALL_M;
    end else if (i.op_class == OP_SYSTEM && i.sys_op == SYS_MRET) begin
      m_mstatus[MSTATUS_MIE]  = m_mstatus[MSTATUS_MPIE];
      m_mstatus[MSTATUS_MPIE] = 1'b1;
    end
  endtask

  function automatic exu_issue_t base_issue(logic [31:0] pc);
    exu_issue_t i;
    i          = '0;
    i.pc       = pc;
    i.op_class = OP_ALU;
    i.alu_op   = ALU_ADD;
    i.sys_op   = SYS_NONE;
    i.rd       = 5'd1;
    i.rd_wen   = 1'b1;
    return i;
  endfunction

  // hands one instruction over and waits for its downstream transfer.
  task automatic run_instr(exu_issue_t ins);
    int cnt;
    @(posedge clk);
    exp_wb     <= predict(ins);
    exp_addr   <= ins.src1 + ins.imm;
    exp_write  <= (ins.op_class == OP_STORE);
    apply_model(ins);
    in_valid_i <= 1'b1;
    in_issue_i <= ins;
    cnt = 0;
    @(negedge clk);
    while (!in_ready_o && cnt < 50) begin
      @(negedge clk);
      cnt++;
    end
    if (!in_ready_o) begin
      timeouts++;
      $display("timeout: the instruction at pc %h was never accepted", ins.pc);
    end
    @(posedge clk);
    in_valid_i <= 1'b0;
    cnt = 0;
    @(negedge clk);
    while (!(wb_valid_o && wb_ready_i) && cnt < 100) begin
      @(negedge clk);
      cnt++;
    end
    if (!(wb_valid_o && wb_ready_i)) begin
      timeouts++;
      $display("timeout: no writeback for the instruction at pc %h", ins.pc);
    end
    @(posedge clk);
  endtask

  task automatic csr_instr(logic [31:0] pc, csr_op_e op, logic [11:0] addr, logic [31:0] v);
    exu_issue_t i;
    i          = base_issue(pc);
    i.op_class = OP_SYSTEM;
    i.sys_op   = SYS_CSR;
    i.csr_op   = op;
    i.csr_addr = addr;
    i.src1     = v;
    run_instr(i);
  endtask

  task automatic sys_instr(logic [31:0] pc, sys_op_e op);
    exu_issue_t i;
    i          = base_issue(pc);
    i.op_class = OP_SYSTEM;
    i.sys_op   = op;
    i.rd_wen   = 1'b0;
    run_instr(i);
  endtask

  initial begin
    exu_issue_t i;
    logic [31:0] addr;
    rng        = 32'h6fea;
    r_ready    = '0;
    r_wait     = '0;
    rst        = 1'b1;
    in_valid_i = 1'b0;
    in_issue_i = '0;
    wb_ready_i = 1'b1;
    wait_sel   = 2'd0;
    exp_wb     = '0;
    exp_addr   = '0;
    exp_write  = 1'b0;
    bp_en      = 1'b0;
    errors     = 0;
    timeouts   = 0;
    m_mstatus  = '0;
    m_mtvec    = '0;
    m_mepc     = '0;
    m_mcause   = '0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;

    // alu.
    for (int n = 0; n < 30; n++) begin
      i        = base_issue(32'h1000 + 4 * n);
      i.alu_op = alu_op_e'(next_rand() % 10);
      i.src1   = next_rand();
      i.src2   = next_rand();
      run_instr(i);
    end

    // each branch condition with equal and unequal operands.
    for (int c = 0; c < 6; c++) begin
      for (int k = 0; k < 3; k++) begin
        i          = base_issue(32'h2000 + 16 * c + 4 * k);
        i.op_class = OP_BRANCH;
        i.br_cond  = br_cond_e'(c);
        i.rd_wen   = 1'b0;
        i.src1     = next_rand();
        i.src2     = (k == 0) ? i.src1 : next_rand();
        i.imm      = 32'h40 + 8 * k;
        run_instr(i);
      end
    end
    i          = base_issue(32'h3000);
    i.op_class = OP_JUMP;
    i.imm      = 32'hffff_ff00;
    run_instr(i);
    i.jalr     = 1'b1;
    i.src1     = 32'h0000_4567;
    i.imm      = 32'h10;
    run_instr(i);

    // from here on the sink stalls at random.
    bp_en <= 1'b1;
    for (int n = 0; n < 8; n++) begin
      addr       = next_rand() & 32'h3fc;
      i          = base_issue(32'h4000 + 8 * n);
      i.op_class = OP_STORE;
      i.rd_wen   = 1'b0;
      i.src1     = addr - 32'h20;
      i.imm      = 32'h20;
      i.src2     = next_rand();
      run_instr(i);
      i          = base_issue(32'h4004 + 8 * n);
      i.op_class = OP_LOAD;
      i.src1     = addr;
      run_instr(i);
    end

    csr_instr(32'h5000, CSR_RW, CSR_MTVEC, 32'h0000_0100);
    csr_instr(32'h5004, CSR_RS, CSR_MTVEC, 32'h0000_0003);
    csr_instr(32'h5008, CSR_RC, CSR_MTVEC, 32'h0000_0001);
    csr_instr(32'h500c, CSR_RS, CSR_MTVEC, 32'h0);
    csr_instr(32'h5010, CSR_RW, CSR_MSTATUS, 32'h80);
    csr_instr(32'h5014, CSR_RW, CSR_MCAUSE, 32'h5);

    sys_instr(32'h6000, SYS_ECALL);
    csr_instr(32'h0104, CSR_RS, CSR_MEPC, 32'h0);
    csr_instr(32'h0108, CSR_RS, CSR_MCAUSE, 32'h0);
    sys_instr(32'h010c, SYS_MRET);
    csr_instr(32'h6004, CSR_RS, CSR_MSTATUS, 32'h0);
    csr_instr(32'h6008, CSR_RC, CSR_MSTATUS, 32'h80);
    sys_instr(32'h600c, SYS_MRET);
    csr_instr(32'h6010, CSR_RS, CSR_MSTATUS, 32'h0);
    sys_instr(32'h6014, SYS_EBREAK);

    repeat (4) @(posedge clk);
    $display("errors %0d timeouts %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- filelist.f
hw/csr_pkg.sv
hw/exu_pkg.sv
hw/exu_ctrl.sv
hw/exu_alu.sv
hw/exu_branch.sv
hw/exu_csr_file.sv
hw/exu_lsu_apb.sv
hw/exu_top.sv
tb/exu_apb_mem.sv
tb/exu_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= exu_tb
FILELIST  ?= filelist.f
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run, and check the log"
	@echo "  clean  remove build output and log"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o sim
	./obj_dir/sim > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
